//--- logic/ecc_pkg.sv
package ecc_pkg;

    // #########################################################################
    // error class and mode encodings
    // #########################################################################

    typedef enum logic [1:0] {
        ERR_NONE   = 2'd0,
        ERR_SINGLE = 2'd1,
        ERR_DOUBLE = 2'd2
    } err_kind_e;

    typedef enum logic {
        MODE_CORRECT = 1'b0,
        MODE_BYPASS  = 1'b1
    } bypass_mode_e;

    // upper bound on codeword positions, index 0 included
    localparam int MAX_CW_LEN = 256;

    // #########################################################################
    // codeword position helpers
    // #########################################################################

    // power-of-two positions hold the Hamming check bits
    function automatic logic is_pow2(input int unsigned pos);
        return (pos != 0) && ((pos & (pos - 1)) == 0);
    endfunction

    // data bit idx goes to the idx-th non power-of-two position, counting from 1
    function automatic int unsigned data_pos(input int unsigned idx);
        int unsigned count;
        int unsigned pos;
        count = 0;
        pos   = 0;
        for (int unsigned p = 1; p < MAX_CW_LEN; p++) begin
            if (!is_pow2(p)) begin
                if (count == idx) begin
                    pos = p;
                end
                count++;
            end
        end
        return pos;
    endfunction

endpackage

//--- logic/ecc_codeword_map.sv
module ecc_codeword_map #(
    parameter int DATA_WIDTH  = 123,
    parameter int CHECK_WIDTH = 8
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [DATA_WIDTH-1:0]              data_in,
    input  logic [CHECK_WIDTH:0]               parity_in,
    input  ecc_pkg::bypass_mode_e              bypass,
    output logic [DATA_WIDTH-1:0]              data_q,
    output logic [CHECK_WIDTH:0]               parity_q,
    output ecc_pkg::bypass_mode_e              bypass_q,
    output logic [DATA_WIDTH+CHECK_WIDTH:0]    codeword
);

    import ecc_pkg::*;

    // position 0 is left unused
    localparam int CW_LEN = DATA_WIDTH + CHECK_WIDTH + 1;

    // #########################################################################
    // input register stage
    // #########################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_q   <= '0;
            parity_q <= '0;
            bypass_q <= MODE_CORRECT;
        end else begin
            data_q   <= data_in;
            parity_q <= parity_in;
            bypass_q <= bypass;
        end
    end

    // #########################################################################
    // spread data onto codeword positions
    // #########################################################################

    // check positions and position 0 carry zero so the slices see data only
    for (genvar p = 0; p < CW_LEN; p++) begin : g_check_slot
        if ((p == 0) || is_pow2(p)) begin : g_zero
            assign codeword[p] = 1'b0;
        end
    end

    for (genvar j = 0; j < DATA_WIDTH; j++) begin : g_data_slot
        localparam int unsigned POS = data_pos(j);
        assign codeword[POS] = data_q[j];
    end

    // the last data bit must land below the codeword length, and that below the bound
    a_last_pos_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        (data_pos(DATA_WIDTH - 1) < CW_LEN) && (CW_LEN <= MAX_CW_LEN)
    );

endmodule

//--- logic/ecc_check_bit.sv
module ecc_check_bit #(
    parameter int DATA_WIDTH  = 123,
    parameter int CHECK_WIDTH = 8,
    parameter int BIT_INDEX   = 0
) (
    input  logic [DATA_WIDTH+CHECK_WIDTH:0] codeword,
    input  logic                            rx_bit,
    output logic                            gen_bit,
    output logic                            syn_bit
);

    localparam int CW_LEN = DATA_WIDTH + CHECK_WIDTH + 1;

    // positions whose index has bit BIT_INDEX set
    function automatic logic [CW_LEN-1:0] cover_mask();
        logic [CW_LEN-1:0] m;
        m = '0;
        for (int p = 1; p < CW_LEN; p++) begin
            m[p] = ((p >> BIT_INDEX) & 1) != 0;
        end
        return m;
    endfunction

    localparam logic [CW_LEN-1:0] COVER = cover_mask();

    // #########################################################################
    // parity over covered positions
    // #########################################################################

    // check positions are zero in the codeword, so covering them costs nothing
    always_comb begin
        gen_bit = ^(codeword & COVER);
    end

    // nonzero means this check bit disagrees with the received one
    always_comb begin
        syn_bit = gen_bit ^ rx_bit;
    end

endmodule

//--- logic/ecc_syndrome_decoder.sv
module ecc_syndrome_decoder #(
    parameter int DATA_WIDTH  = 123,
    parameter int CHECK_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_WIDTH-1:0] data_q,
    input  logic [CHECK_WIDTH-1:0] gen_bits,
    input  logic [CHECK_WIDTH-1:0] syn_bits,
    input  logic                  rx_overall,
    input  ecc_pkg::bypass_mode_e bypass_q,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic [CHECK_WIDTH:0]  parity_out,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    import ecc_pkg::*;

    localparam int CW_LEN = DATA_WIDTH + CHECK_WIDTH + 1;

    // one flag per position that holds a data bit
    function automatic logic [MAX_CW_LEN-1:0] data_slots();
        logic [MAX_CW_LEN-1:0] m;
        m = '0;
        for (int unsigned p = 1; p < CW_LEN; p++) begin
            m[p] = !is_pow2(p);
        end
        return m;
    endfunction

    localparam logic [MAX_CW_LEN-1:0] DATA_SLOTS = data_slots();

    logic                  overall_gen;
    logic                  overall_mm;
    logic                  syn_zero;
    logic                  syn_in_cw;
    logic                  syn_on_data;
    logic                  fix_en;
    err_kind_e             kind;
    logic [DATA_WIDTH-1:0] corr_mask;
    logic [DATA_WIDTH-1:0] data_fix;

    // #########################################################################
    // overall parity and classification
    // #########################################################################

    assign overall_gen = (^data_q) ^ (^gen_bits);

    // received check bits are gen ^ syn, so the whole received word folds in here
    assign overall_mm = (^data_q) ^ (^(syn_bits ^ gen_bits)) ^ rx_overall;

    assign syn_zero    = (syn_bits == '0);
    assign syn_in_cw   = (syn_bits < CW_LEN);
    assign syn_on_data = DATA_SLOTS[syn_bits];

    always_comb begin
        if (bypass_q == MODE_BYPASS) begin
            kind = ERR_NONE;
        end else if (overall_mm) begin
            // odd number of flips, correctable only if it names a real position
            kind = (syn_zero || syn_in_cw) ? ERR_SINGLE : ERR_DOUBLE;
        end else if (!syn_zero) begin
            kind = ERR_DOUBLE;
        end else begin
            kind = ERR_NONE;
        end
    end

    // #########################################################################
    // correction
    // #########################################################################

    for (genvar j = 0; j < DATA_WIDTH; j++) begin : g_corr
        localparam int unsigned POS = data_pos(j);
        assign corr_mask[j] = (syn_bits == POS[CHECK_WIDTH-1:0]);
    end

    // a single hit on a check position leaves the data alone
    assign fix_en   = (kind == ERR_SINGLE) && syn_on_data;
    assign data_fix = fix_en ? (data_q ^ corr_mask) : data_q;

    // #########################################################################
    // output register stage
    // #########################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out   <= '0;
            parity_out <= '0;
            sbit_err   <= 1'b0;
            dbit_err   <= 1'b0;
        end else begin
            data_out   <= data_fix;
            parity_out <= {overall_gen, gen_bits};
            sbit_err   <= (kind == ERR_SINGLE);
            dbit_err   <= (kind == ERR_DOUBLE);
        end
    end

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(sbit_err && dbit_err)
    );

    // a word taken in bypass reports clean on the next cycle
    a_bypass_quiet: assert property (
        @(posedge clk) disable iff (!arst_n)
        (bypass_q == MODE_BYPASS) |=> (!sbit_err && !dbit_err)
    );

endmodule

//--- logic/ecc_secded_top.sv
module ecc_secded_top #(
    parameter int DATA_WIDTH  = 123,
    parameter int CHECK_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic [CHECK_WIDTH:0]  parity_in,
    input  logic                  bypass,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic [CHECK_WIDTH:0]  parity_out,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    import ecc_pkg::*;

    logic [DATA_WIDTH+CHECK_WIDTH:0] codeword;
    logic [DATA_WIDTH-1:0]           data_q;
    logic [CHECK_WIDTH:0]            parity_q;
    bypass_mode_e                    bypass_q;
    logic [CHECK_WIDTH-1:0]          gen_bits;
    logic [CHECK_WIDTH-1:0]          syn_bits;

    // #########################################################################
    // stage 1: input registers and position mapping
    // #########################################################################

    ecc_codeword_map #(
        .DATA_WIDTH  (DATA_WIDTH),
        .CHECK_WIDTH (CHECK_WIDTH)
    ) i_codeword_map (
        .clk       (clk),
        .arst_n    (arst_n),
        .data_in   (data_in),
        .parity_in (parity_in),
        .bypass    (bypass_mode_e'(bypass)),
        .data_q    (data_q),
        .parity_q  (parity_q),
        .bypass_q  (bypass_q),
        .codeword  (codeword)
    );

    // one slice per Hamming check bit, the overall bit is handled in the decoder
    for (genvar k = 0; k < CHECK_WIDTH; k++) begin : g_check
        ecc_check_bit #(
            .DATA_WIDTH  (DATA_WIDTH),
            .CHECK_WIDTH (CHECK_WIDTH),
            .BIT_INDEX   (k)
        ) i_check_bit (
            .codeword (codeword),
            .rx_bit   (parity_q[k]),
            .gen_bit  (gen_bits[k]),
            .syn_bit  (syn_bits[k])
        );
    end

    // #########################################################################
    // stage 2: decode, correct and register outputs
    // #########################################################################

    ecc_syndrome_decoder #(
        .DATA_WIDTH  (DATA_WIDTH),
        .CHECK_WIDTH (CHECK_WIDTH)
    ) i_syndrome_decoder (
        .clk        (clk),
        .arst_n     (arst_n),
        .data_q     (data_q),
        .gen_bits   (gen_bits),
        .syn_bits   (syn_bits),
        .rx_overall (parity_q[CHECK_WIDTH]),
        .bypass_q   (bypass_q),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

//--- sim/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // release on a falling edge, half a period away from the capturing edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- sim/tb_ecc_secded.sv
module tb_ecc_secded;

    import ecc_pkg::*;

    localparam int DATA_WIDTH  = 123;
    localparam int CHECK_WIDTH = 8;
    localparam int TOTAL_BITS  = DATA_WIDTH + CHECK_WIDTH + 1;
    localparam int CLK_PERIOD  = 10;
    localparam int N_TESTS     = 3000;
    localparam int WATCHDOG    = (N_TESTS + 10) * CLK_PERIOD;

    logic                   clk;
    logic                   arst_n;
    logic [DATA_WIDTH-1:0]  data_in;
    logic [CHECK_WIDTH:0]   parity_in;
    logic                   bypass;
    logic [DATA_WIDTH-1:0]  data_out;
    logic [CHECK_WIDTH:0]   parity_out;
    logic                   sbit_err;
    logic                   dbit_err;

    integer                 seed = 71;
    int                     pos_of [DATA_WIDTH];

    // words in flight are popped two cycles after they were driven
    logic [DATA_WIDTH-1:0]  exp_data_q [$];
    logic [CHECK_WIDTH:0]   exp_parity_q [$];
    err_kind_e              exp_kind_q [$];

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) i_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    ecc_secded_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .CHECK_WIDTH (CHECK_WIDTH)
    ) i_ecc_secded_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // ########################################################################
    // reference model
    // ########################################################################

    // textbook extended Hamming where the overall bit covers data and bits 0..7
    function automatic logic [CHECK_WIDTH:0] encode_word(input logic [DATA_WIDTH-1:0] d);
        logic [CHECK_WIDTH:0] c;
        c = '0;
        for (int k = 0; k < CHECK_WIDTH; k++) begin
            for (int j = 0; j < DATA_WIDTH; j++) begin
                if (((pos_of[j] >> k) & 1) != 0) begin
                    c[k] = c[k] ^ d[j];
                end
            end
        end
        c[CHECK_WIDTH] = (^d) ^ (^c[CHECK_WIDTH-1:0]);
        return c;
    endfunction

    task automatic pick_below(input int n, output int v);
        int r;
        r = $random(seed);
        v = (r & 32'h7fff_ffff) % n;
    endtask

    // indices below DATA_WIDTH are data bits and the rest are check bits
    task automatic flip_bit(input int idx, inout logic [DATA_WIDTH-1:0] d,
                            inout logic [CHECK_WIDTH:0] p);
        if (idx < DATA_WIDTH) begin
            d[idx] = ~d[idx];
        end else begin
            p[idx - DATA_WIDTH] = ~p[idx - DATA_WIDTH];
        end
    endtask

    task automatic make_word();
        logic [127:0]           raw;
        logic [DATA_WIDTH-1:0]  orig;
        logic [DATA_WIDTH-1:0]  sent_d;
        logic [CHECK_WIDTH:0]   sent_p;
        logic [DATA_WIDTH-1:0]  exp_d;
        err_kind_e              kind;
        logic                   by;
        int                     cls;
        int                     a;
        int                     b;
        raw    = {$random(seed), $random(seed), $random(seed), $random(seed)};
        orig   = raw[DATA_WIDTH-1:0];
        sent_d = orig;
        sent_p = encode_word(orig);
        by     = 1'b0;
        pick_below(5, cls);
        // class 4 is bypass on top of one of the other injections
        if (cls == 4) begin
            by = 1'b1;
            pick_below(4, cls);
        end
        case (cls)
            1: begin
                pick_below(DATA_WIDTH, a);
                flip_bit(a, sent_d, sent_p);
                kind = ERR_SINGLE;
            end
            2: begin
                pick_below(CHECK_WIDTH + 1, a);
                flip_bit(DATA_WIDTH + a, sent_d, sent_p);
                kind = ERR_SINGLE;
            end
            3: begin
                pick_below(TOTAL_BITS, a);
                pick_below(TOTAL_BITS - 1, b);
                if (b >= a) begin
                    b = b + 1;
                end
                flip_bit(a, sent_d, sent_p);
                flip_bit(b, sent_d, sent_p);
                kind = ERR_DOUBLE;
            end
            default: begin
                kind = ERR_NONE;
            end
        endcase
        // double errors and bypass leave the received data as it came
        if (by || (cls == 3)) begin
            exp_d = sent_d;
        end else begin
            exp_d = orig;
        end
        if (by) begin
            kind = ERR_NONE;
        end
        data_in   = sent_d;
        parity_in = sent_p;
        bypass    = by;
        exp_data_q.push_back(exp_d);
        exp_parity_q.push_back(encode_word(sent_d));
        exp_kind_q.push_back(kind);
    endtask

    // ########################################################################
    // compare tasks
    // ########################################################################

    task automatic check_data(input logic [DATA_WIDTH-1:0] exp_val,
                              input logic [DATA_WIDTH-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED at %0t: data_out expected %h got %h", $time, exp_val, act_val);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_parity(input logic [CHECK_WIDTH:0] exp_val,
                                input logic [CHECK_WIDTH:0] act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED at %0t: parity_out expected %h got %h",
                     $time, exp_val, act_val);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_flags(input err_kind_e exp_kind, input logic s, input logic d);
        logic [1:0] exp_val;
        exp_val = {exp_kind == ERR_SINGLE, exp_kind == ERR_DOUBLE};
        if ({s, d} !== exp_val) begin
            $display("CHECK FAILED at %0t: {sbit_err,dbit_err} expected %b (%s) got %b",
                     $time, exp_val, exp_kind.name(), {s, d});
            $display("ERRORS FOUND");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_idle();
        check_data('0, data_out);
        check_parity('0, parity_out);
        check_flags(ERR_NONE, sbit_err, dbit_err);
    endtask

    task automatic compare_next();
        check_data(exp_data_q.pop_front(), data_out);
        check_parity(exp_parity_q.pop_front(), parity_out);
        check_flags(exp_kind_q.pop_front(), sbit_err, dbit_err);
    endtask

    // ########################################################################
    // main sequence and watchdog
    // ########################################################################

    initial begin
        int p;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        p = 1;
        for (int j = 0; j < DATA_WIDTH; j++) begin
            while ((p & (p - 1)) == 0) begin
                p++;
            end
            pos_of[j] = p;
            p++;
        end
        @(negedge clk);
        check_idle();
        wait (arst_n === 1'b1);
        // outputs lag by two cycles, so the first two looks see the reset values
        for (int cycle = 0; cycle < N_TESTS + 2; cycle++) begin
            if (cycle > 0) begin
                @(negedge clk);
            end
            if (cycle < 2) begin
                check_idle();
            end else begin
                compare_next();
            end
            if (cycle < N_TESTS) begin
                make_word();
            end else begin
                data_in   = '0;
                parity_in = '0;
                bypass    = 1'b0;
            end
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("timeout: the run hung and did not finish within %0d time units", WATCHDOG);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- ecc_secded.f
logic/ecc_pkg.sv
logic/ecc_codeword_map.sv
logic/ecc_check_bit.sv
logic/ecc_syndrome_decoder.sv
logic/ecc_secded_top.sv
sim/tb_clock_gen.sv
sim/tb_ecc_secded.sv

//--- Bender.yml
package:
  name: ecc_secded

sources:
  # package first, then the datapath leaves and the top level
  - files:
      - logic/ecc_pkg.sv
      - logic/ecc_codeword_map.sv
      - logic/ecc_check_bit.sv
      - logic/ecc_syndrome_decoder.sv
      - logic/ecc_secded_top.sv

  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_ecc_secded.sv
